// ==== include/imul_config.svh ====
`ifndef IMUL_CONFIG_SVH
`define IMUL_CONFIG_SVH

// operand and result width in bits
`define IMUL_WIDTH 16

// cycles from the start strobe to the done pulse
// one register in operandPrep, one in resultSelect
`define IMUL_LATENCY 2

`endif

// ==== design/imulPkg.sv ====
`include "imul_config.svh"

package imulPkg;

	// multiply opcodes
	typedef enum logic [1:0] {
		MUL_LO  = 2'b00, // low half of the product
		MUL_HU  = 2'b01, // high half, unsigned x unsigned
		MUL_HS  = 2'b10, // high half, signed x signed
		MUL_HSU = 2'b11  // high half, signed a x unsigned b
	} imulOpE;

	typedef logic [`IMUL_WIDTH-1:0]   operandT; // single word
	typedef logic [2*`IMUL_WIDTH-1:0] productT; // double word

endpackage

// ==== design/arrayMultiplier.sv ====
`include "imul_config.svh"

// Unsigned array multiplier. Each row i adds the partial product a & b[i]
// into the running sum in carry-save form, so carries move diagonally to
// the next row. The last row leaves a sum and a carry vector which a ripple
// adder merges into the upper half of the product.
module arrayMultiplier (
	input  imulPkg::operandT      a,
	input  imulPkg::operandT      b,
	output wire imulPkg::productT product
);
	import imulPkg::*;

	localparam int W = `IMUL_WIDTH;

	wire operandT pp [W];              // pp[i][j] = a[j] & b[i], weight i+j
	wire operandT rowSum [W];          // sum out of cell (i,j), weight i+j
	wire operandT rowCarry [1:W-1];    // carry out of cell (i,j), weight i+j+1
	wire logic [W-2:0] rippleCarry;    // carries of the final adder row

	generate
		if (W < 4) begin : gWidthCheck
			$error("arrayMultiplier needs IMUL_WIDTH of 4 or more");
		end
	endgenerate

	// partial product rows
	generate
		for (genvar i = 0; i < W; i++) begin : gPartial
			assign pp[i] = a & {W{b[i]}};
		end
	endgenerate

	assign rowSum[0] = pp[0]; // row 0 is the bare partial product

	// carry-save grid, rows 1 to W-1
	generate
		for (genvar i = 1; i < W; i++) begin : gRow
			for (genvar j = 0; j < W; j++) begin : gCell
				wire x;
				wire y;
				wire z;

				assign x = pp[i][j];

				if (j == W-1) begin : gLeftEdge
					assign y = 1'b0; // nothing above the msb column
				end else begin : gInner
					assign y = rowSum[i-1][j+1]; // previous sum, same weight
				end

				if (i == 1) begin : gFirstRow
					assign z = 1'b0; // row 0 makes no carries
				end else begin : gCarryIn
					assign z = rowCarry[i-1][j]; // diagonal carry
				end

				assign rowSum[i][j]   = x ^ y ^ z;
				assign rowCarry[i][j] = (x & y) | (x & z) | (y & z);
			end
		end
	endgenerate

	// low half falls out of the right column of the grid
	generate
		for (genvar i = 0; i < W; i++) begin : gLow
			assign product[i] = rowSum[i][0];
		end
	endgenerate

	// final ripple row merges the last sum and carry vectors
	generate
		for (genvar k = 0; k < W; k++) begin : gRipple
			if (k == 0) begin : gRippleFirst
				// no carry in yet, half adder
				assign product[W] = rowSum[W-1][1] ^ rowCarry[W-1][0];
				assign rippleCarry[0] = rowSum[W-1][1] & rowCarry[W-1][0];
			end else if (k == W-1) begin : gRippleTop
				// top bit: no sum bit above, and a carry out of here
				// would exceed 2W bits, which a W x W product never does
				assign product[2*W-1] = rowCarry[W-1][W-1] ^ rippleCarry[W-2];
			end else begin : gRippleMid
				wire x;
				wire y;
				wire z;

				assign x = rowSum[W-1][k+1];
				assign y = rowCarry[W-1][k];
				assign z = rippleCarry[k-1];

				assign product[W+k]   = x ^ y ^ z;
				assign rippleCarry[k] = (x & y) | (x & z) | (y & z);
			end
		end
	endgenerate

endmodule

// ==== design/operandPrep.sv ====
`include "imul_config.svh"

// First stage. Turns signed operands into magnitudes so the unsigned array
// can be used for every opcode, and remembers whether to negate the product.
module operandPrep (
	input  logic             clk,
	input  logic             arstN,
	input  logic             start,
	input  imulPkg::imulOpE  op,
	input  imulPkg::operandT a,
	input  imulPkg::operandT b,
	output imulPkg::operandT magA,
	output imulPkg::operandT magB,
	output logic             negate,
	output imulPkg::imulOpE  opReg,
	output logic             prepValid
);
	import imulPkg::*;

	localparam int W = `IMUL_WIDTH;

	logic    signedA;  // a is taken as two's complement
	logic    signedB;  // b is taken as two's complement
	logic    negA;
	logic    negB;
	operandT absA;
	operandT absB;

	// lo and hu are plain unsigned
	assign signedA = (op == MUL_HS) || (op == MUL_HSU);
	assign signedB = (op == MUL_HS);

	assign negA = signedA & a[W-1];
	assign negB = signedB & b[W-1];

	// most negative value maps to 2**(W-1), still fits unsigned
	assign absA = negA ? ~a + operandT'(1) : a;
	assign absB = negB ? ~b + operandT'(1) : b;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			prepValid <= 1'b0;
		end else begin
			prepValid <= start;
		end
	end

	// operand payload, only loaded on a strobe
	always_ff @(posedge clk) begin
		if (start) begin
			magA   <= absA;
			magB   <= absB;
			negate <= negA ^ negB; // one negative factor flips the sign
			opReg  <= op;
		end
	end

	// an X opcode would silently pick a wrong half two cycles later
	opKnown: assert property (@(posedge clk) disable iff (!arstN)
		start |-> !$isunknown(op))
		else $error("operandPrep: opcode is X on start");

endmodule

// ==== design/resultSelect.sv ====
`include "imul_config.svh"

// Second stage. Restores the sign of the array product, picks the half the
// opcode asks for and registers it together with the done pulse.
module resultSelect (
	input  logic             clk,
	input  logic             arstN,
	input  imulPkg::productT product,
	input  logic             negate,
	input  imulPkg::imulOpE  opReg,
	input  logic             prepValid,
	output imulPkg::operandT result,
	output logic             done
);
	import imulPkg::*;

	localparam int W = `IMUL_WIDTH;

	productT signedProduct; // product with sign restored
	operandT halfSel;

	// negate across the full double word so the high half stays right
	assign signedProduct = negate ? ~product + productT'(1) : product;

	assign halfSel = (opReg == MUL_LO) ? signedProduct[W-1:0]
		: signedProduct[2*W-1:W];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
			done   <= 1'b0;
		end else begin
			done <= prepValid; // one pulse per accepted operation
			if (prepValid) begin
				result <= halfSel; // holds until the next operation
			end
		end
	end

	// magnitudes multiply to less than 2**(2W-1) so negation sets the top bit
	signNeg: assert property (@(posedge clk) disable iff (!arstN)
		prepValid && negate && (product != '0) |-> signedProduct[2*W-1])
		else $error("resultSelect: negated product came out positive");

	resultKnown: assert property (@(posedge clk) disable iff (!arstN)
		done |-> !$isunknown(result))
		else $error("resultSelect: result has X while done is high");

endmodule

// ==== design/imulUnit.sv ====
`include "imul_config.svh"

// Integer multiply unit, two pipeline stages around the array multiplier.
// A new operation may start every cycle, results come back in order.
module imulUnit (
	input  logic             clk,
	input  logic             arstN,
	input  logic             start,
	input  imulPkg::imulOpE  op,
	input  imulPkg::operandT a,
	input  imulPkg::operandT b,
	output imulPkg::operandT result,
	output logic             done
);
	import imulPkg::*;

	operandT magA;
	operandT magB;
	logic    negate;
	imulOpE  opReg;
	logic    prepValid;
	productT product;

	operandPrep uPrep (
		.clk       (clk),
		.arstN     (arstN),
		.start     (start),
		.op        (op),
		.a         (a),
		.b         (b),
		.magA      (magA),
		.magB      (magB),
		.negate    (negate),
		.opReg     (opReg),
		.prepValid (prepValid)
	);

	// combinational, settles within the second cycle
	arrayMultiplier uArray (
		.a       (magA),
		.b       (magB),
		.product (product)
	);

	resultSelect uSelect (
		.clk       (clk),
		.arstN     (arstN),
		.product   (product),
		.negate    (negate),
		.opReg     (opReg),
		.prepValid (prepValid),
		.result    (result),
		.done      (done)
	);

	// end to end latency through both stages
	startToDone: assert property (@(posedge clk) disable iff (!arstN)
		start |-> ##(`IMUL_LATENCY) done)
		else $error("imulUnit: done missing %0d cycles after start", `IMUL_LATENCY);

endmodule

// ==== testbench/imulUnitTb.sv ====
`include "imul_config.svh"

module imulUnitTb;
	timeunit 1ns;
	timeprecision 100ps;

	import imulPkg::*;

	localparam int W = `IMUL_WIDTH;
	localparam int lat = `IMUL_LATENCY;
	localparam int clkPeriod = 8;
	localparam int loOps = 300;
	localparam int huOps = 100 + 6;          // random plus edge cases
	localparam int hsOps = 2 * (100 + 6);    // both signed opcodes
	localparam int mixOps = 200 + 100;       // burst, then gapped
	localparam int maxGap = 3;
	localparam int totalOps = loOps + huOps + hsOps + mixOps;
	// every op may be followed by a full gap, plus reset and drains
	localparam int budgetCycles = 4 + totalOps * (maxGap + 1) + 6 * (lat + 6) + 20;
	localparam operandT allOnes = '1;
	localparam operandT minNeg = {1'b1, {(W-1){1'b0}}};

	logic    clk = 1'b0;
	logic    arstN;
	logic    start;
	imulOpE  op;
	operandT a;
	operandT b;
	operandT result;
	logic    done;

	// reference model, one entry per strobe
	operandT expQ [$];
	int      edgeQ [$];                      // edge that opens the strobe cycle
	imulOpE  opQ [$];
	operandT aQ [$];
	operandT bQ [$];

	int cycleCount = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int testErrStart = 0;
	int strobeCount = 0;
	int doneCount = 0;

	imulUnit DUT (
		.clk    (clk),
		.arstN  (arstN),
		.start  (start),
		.op     (op),
		.a      (a),
		.b      (b),
		.result (result),
		.done   (done)
	);

	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk) cycleCount++;

	// wide integer arithmetic, independent of the array
	function automatic operandT expectedResult(imulOpE opc, operandT x, operandT y);
		longint sx;
		longint ux;
		longint sy;
		longint uy;
		longint full;
		sx = longint'($signed(x));
		ux = longint'(x);
		sy = longint'($signed(y));
		uy = longint'(y);
		case (opc)
			MUL_LO:  full = ux * uy;
			MUL_HU:  full = ux * uy;
			MUL_HS:  full = sx * sy;
			default: full = sx * uy;     // signed a, unsigned b
		endcase
		if (opc == MUL_LO) begin
			return full[W-1:0];
		end
		return full[2*W-1:W];
	endfunction

	task automatic checkResult(operandT expected, operandT actual, imulOpE opc,
		operandT x, operandT y);
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0d ns: %s a=%h b=%h expected %h, got %h",
				$time, opc.name(), x, y, expected, actual);
		end
	endtask

	task automatic checkDone(logic expected, logic actual);
		if (actual !== expected) begin
			errorCount++;
			if (actual === 1'b1) begin
				$display("At %0d ns done pulsed while no operation was due (%0d queued)",
					$time, edgeQ.size());
			end else begin
				$display("At %0d ns an expected done pulse did not arrive", $time);
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		logic due;
		if (arstN === 1'b1) begin
			due = (edgeQ.size() != 0) && (edgeQ[0] + lat == cycleCount);
			checkDone(due, done);
			if (due) begin
				if (done === 1'b1) begin
					checkResult(expQ[0], result, opQ[0], aQ[0], bQ[0]);
				end
				void'(expQ.pop_front());
				void'(edgeQ.pop_front());
				void'(opQ.pop_front());
				void'(aQ.pop_front());
				void'(bQ.pop_front());
			end
			if (done === 1'b1) begin
				doneCount++;
			end
		end
	end

	task automatic issue(imulOpE opc, operandT x, operandT y);
		@(posedge clk);
		#1;
		start = 1'b1;
		op = opc;
		a = x;
		b = y;
		expQ.push_back(expectedResult(opc, x, y));
		edgeQ.push_back(cycleCount); // strobe cycle opens at this edge
		opQ.push_back(opc);
		aQ.push_back(x);
		bQ.push_back(y);
		strobeCount++;
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			start = 1'b0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (expQ.size() != 0) begin
			idle(1);
		end
		idle(1);
	endtask

	task automatic beginTest();
		testErrStart = errorCount;
	endtask

	task automatic endTest(string name);
		if (errorCount == testErrStart) begin
			passCount++;
			$display("%-10s passed", name);
		end else begin
			failCount++;
			$display("%-10s %0d errors", name, errorCount - testErrStart);
		end
	endtask

	task automatic signedEdges(imulOpE opc);
		issue(opc, minNeg, minNeg);
		issue(opc, minNeg, allOnes);     // -1 for MUL_HS, max unsigned for MUL_HSU
		issue(opc, allOnes, minNeg);
		issue(opc, allOnes, allOnes);
		issue(opc, minNeg, operandT'(1));
		issue(opc, '0, minNeg);
	endtask

	initial begin
		#(budgetCycles * clkPeriod);
		$display("Watchdog: run did not finish within %0d cycles", budgetCycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		int baseStrobes;
		int baseDones;
		void'($urandom(9587));
		arstN = 1'b0;
		start = 1'b0;
		op = MUL_LO;
		a = '0;
		b = '0;
		repeat (2) @(posedge clk);
		#1;
		arstN = 1'b1;

		beginTest();
		idle(3);
		checkDone(1'b0, done);
		checkResult('0, result, MUL_LO, '0, '0);
		endTest("reset");

		beginTest();
		repeat (loOps) issue(MUL_LO, operandT'($urandom), operandT'($urandom));
		drain();
		endTest("mulLo");

		beginTest();
		issue(MUL_HU, allOnes, allOnes);
		issue(MUL_HU, '0, allOnes);
		issue(MUL_HU, allOnes, '0);
		issue(MUL_HU, operandT'(1), allOnes);
		issue(MUL_HU, allOnes, operandT'(1));
		issue(MUL_HU, minNeg, minNeg);
		repeat (100) issue(MUL_HU, operandT'($urandom), operandT'($urandom));
		drain();
		endTest("mulHu");

		beginTest();
		signedEdges(MUL_HS);
		signedEdges(MUL_HSU);
		repeat (100) issue(MUL_HS, operandT'($urandom), operandT'($urandom));
		repeat (100) issue(MUL_HSU, operandT'($urandom), operandT'($urandom));
		drain();
		endTest("mulSigned");

		beginTest();
		baseStrobes = strobeCount;
		baseDones = doneCount;
		repeat (200) begin
			issue(imulOpE'($urandom_range(0, 3)), operandT'($urandom), operandT'($urandom));
		end
		repeat (100) begin
			issue(imulOpE'($urandom_range(0, 3)), operandT'($urandom), operandT'($urandom));
			idle($urandom_range(0, maxGap));
		end
		drain();
		if (doneCount - baseDones != strobeCount - baseStrobes) begin
			errorCount++;
			$display("Saw %0d done pulses for %0d strobes", doneCount - baseDones,
				strobeCount - baseStrobes);
		end
		endTest("pipeline");

		$display("Tests: %0d passed, %0d failed, %0d errors", passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
design/imulPkg.sv
design/arrayMultiplier.sv
design/operandPrep.sv
design/resultSelect.sv
design/imulUnit.sv
testbench/imulUnitTb.sv

// ==== Makefile ====
# Verilator simulation of the integer multiply unit

TOP := imulUnitTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir
